// File: project.f
+incdir+logic
logic/adc_frame_pkg.sv
logic/adc_pattern_pkg.sv
logic/adc_deserialise.sv
logic/adc_pattern_checker.sv
logic/adc_link_top.sv
verification/tb_clock_gen.sv
verification/tb_adc_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ADC link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_adc_link -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/Vtb_adc_link)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi

// File: verification/adc_link_tests.txt
# name  mode(0 off,1 fixed,2 ramp)  phase(0 rise,1 fall)  words  inject
# clear_after(word index, -1 none)  ramp_start(hex)  expected_error_count
rise_off_random     0 0  8 0 -1 000 0
fall_off_random     0 1  8 0 -1 000 0

# fixed pattern, clean and with flipped bits in the last words
fixed_clean_rise    1 0 10 0 -1 000 0
fixed_clean_fall    1 1 10 0 -1 000 0
fixed_one_error     1 0 10 1 -1 000 1
fixed_three_fall    1 1 10 3 -1 000 3

# ramp, with wrap past 4095 and one skipped value on lane 0
ramp_rise           2 0 12 0 -1 100 0
ramp_wrap_fall      2 1 12 0 -1 ffa 0
ramp_skip           2 0 12 1 -1 7f8 2

# clear after word 6, three bad words before and three after
fixed_clear         1 0 10 6  6 000 3

// File: verification/tb_adc_link.sv
`timescale 1ns/1ps

`include "adc_defs.svh"

module tb_adc_link import adc_frame_pkg::*, adc_pattern_pkg::*; ();

  logic                            clk;
  logic                            reset;
  logic [`ADC_LANES-1:0]           serial_rise;
  logic [`ADC_LANES-1:0]           serial_fall;
  logic                            fclk_rise;
  logic                            fclk_fall;
  pattern_mode_t                   pattern_mode;
  logic                            error_clear;
  logic [`ADC_LANES*`ADC_BITS-1:0] samples;
  logic                            sample_valid;
  frame_state_t                    frame_state;
  logic [15:0]                     error_count;
  logic                            pattern_ok;

  // test records from the tests file
  logic [8*24-1:0] t_name [32];
  int t_mode [32];
  int t_phase [32];
  int t_words [32];
  int t_inject [32];
  int t_clear [32];
  int t_start [32];
  int t_expect [32];
  int num_tests;
  int total_words;
  int watchdog_cycles;
  logic tests_loaded;
  int errors;
  int passed;
  int failed;

  tb_clock_gen clock0 (.clk(clk));

  adc_link_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .serial_rise  (serial_rise),
    .serial_fall  (serial_fall),
    .fclk_rise    (fclk_rise),
    .fclk_fall    (fclk_fall),
    .pattern_mode (pattern_mode),
    .error_clear  (error_clear),
    .samples      (samples),
    .sample_valid (sample_valid),
    .frame_state  (frame_state),
    .error_count  (error_count),
    .pattern_ok   (pattern_ok)
  );

  task automatic load_tests();
    int fd;
    int r;
    string line;
    fd = $fopen("verification/adc_link_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the tests file verification/adc_link_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        r = $fgets(line, fd);
        // skip blank and comment lines
        if (r > 1 && line[0] != "#") begin
          r = $sscanf(line, "%s %d %d %d %d %d %h %d", t_name[num_tests],
                      t_mode[num_tests], t_phase[num_tests], t_words[num_tests],
                      t_inject[num_tests], t_clear[num_tests], t_start[num_tests],
                      t_expect[num_tests]);
          if (r == 8 && num_tests < 32) begin
            total_words += t_words[num_tests];
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(int i);
    logic [`ADC_LANES*`ADC_BITS-1:0] words [$];
    logic [`ADC_LANES*`ADC_BITS-1:0] w;
    logic [`ADC_LANES*`ADC_BITS-1:0] sync_word;
    logic [`ADC_LANES-1:0] slot_data [$];
    logic slot_fclk [$];
    logic [`ADC_LANES-1:0] d;
    logic [11:0] lane_val;
    logic dup;
    logic exp_ok;
    frame_state_t exp_state;
    int nw;
    int k;
    int npairs;
    int it;
    int rx_count;
    int settle;
    int clear_state;
    int bad_before;
    int test_errors;
    nw = t_words[i];
    k = t_inject[i];
    test_errors = 0;
    exp_state = (t_phase[i] == 1) ? FRAME_FALL : FRAME_RISE;
    exp_ok = (t_mode[i] == 2) || (t_mode[i] == 1 && k == 0);

    // words per lane from the pattern rules
    for (int j = 0; j < nw; j++) begin
      w = '0;
      for (int n = 0; n < `ADC_LANES; n++) begin
        if (t_mode[i] == 0) begin
          // random with every lane different
          do begin
            lane_val = 12'($urandom);
            dup = 1'b0;
            for (int m = 0; m < n; m++) begin
              if (w[m*12 +: 12] == lane_val) dup = 1'b1;
            end
          end while (dup);
        end else if (t_mode[i] == 1) begin
          lane_val = `ADC_FIXED_PATTERN;
          // one flipped bit in each of the last k words
          if (j >= nw - k && n == j % `ADC_LANES) begin
            lane_val[j % 12] = ~lane_val[j % 12];
          end
        end else begin
          lane_val = 12'(t_start[i] + 256 * n + j);
          if (k > 0 && j == nw - 3 && n == 0) lane_val = lane_val + 12'd1;
        end
        w[n*12 +: 12] = lane_val;
      end
      words.push_back(w);
    end

    // lead word that fits the pattern and may be dropped while the frame locks
    sync_word = '0;
    for (int n = 0; n < `ADC_LANES; n++) begin
      if (t_mode[i] == 1) sync_word[n*12 +: 12] = `ADC_FIXED_PATTERN;
      if (t_mode[i] == 2) sync_word[n*12 +: 12] = 12'(t_start[i] + 256 * n - 1);
    end

    // half-cycle slots start with 3 idle cycles and one extra slot in fall phase
    for (int s = 0; s < 6 + t_phase[i]; s++) begin
      slot_data.push_back('0);
      slot_fclk.push_back(1'b0);
    end
    for (int j = 0; j <= nw; j++) begin
      w = (j == 0) ? sync_word : words[j-1];
      for (int b = 0; b < `ADC_BITS; b++) begin
        for (int n = 0; n < `ADC_LANES; n++) d[n] = w[n*12 + b];
        slot_data.push_back(d);
        // frame clock high for the first six slots of a word
        slot_fclk.push_back(b < 6);
      end
    end
    if (slot_data.size() % 2 == 1) begin
      slot_data.push_back('0);
      slot_fclk.push_back(1'b0);
    end
    npairs = slot_data.size() / 2;

    bad_before = 0;
    for (int j = 0; j <= t_clear[i]; j++) begin
      if (j >= nw - k) bad_before++;
    end

    reset = 1'b1;
    serial_rise = '0;
    serial_fall = '0;
    fclk_rise = 1'b0;
    fclk_fall = 1'b0;
    error_clear = 1'b0;
    pattern_mode = PATTERN_OFF;
    repeat (10) @(negedge clk);
    if (sample_valid !== 1'b0 || error_count !== 16'd0 || pattern_ok !== 1'b0 ||
        frame_state !== FRAME_HUNT) begin
      $display("MISMATCH at %0t: outputs not at reset values", $time);
      test_errors++;
    end
    reset = 1'b0;
    pattern_mode = pattern_mode_t'(t_mode[i]);

    it = 0;
    rx_count = 0;
    settle = 0;
    clear_state = 0;
    while (1) begin
      if (it > 0) begin
        // clear sequence follows the chosen word
        if (clear_state == 1) begin
          if (error_count !== 16'(bad_before)) begin
            $display("MISMATCH at %0t: count %0d before clear, expected %0d",
                     $time, error_count, bad_before);
            test_errors++;
          end
          error_clear = 1'b1;
          clear_state = 2;
        end else if (clear_state == 2) begin
          if (error_count !== 16'd0) begin
            $display("MISMATCH at %0t: count %0d after clear", $time, error_count);
            test_errors++;
          end
          error_clear = 1'b0;
          clear_state = 3;
        end
        // strobes before iteration 16 belong to the lead word
        if (sample_valid && it >= 16 && rx_count < nw) begin
          if (samples !== words[rx_count]) begin
            $display("MISMATCH at %0t: word %0d got %h expected %h", $time, rx_count,
                     samples, words[rx_count]);
            test_errors++;
          end
          if (frame_state !== exp_state) begin
            $display("MISMATCH at %0t: frame_state %0d expected %0d", $time,
                     frame_state, exp_state);
            test_errors++;
          end
          if (rx_count == t_clear[i]) clear_state = 1;
          rx_count++;
        end
        if (rx_count == nw) settle++;
        if (settle >= 2) break;
      end
      if (it < npairs) begin
        serial_rise = slot_data[2*it];
        serial_fall = slot_data[2*it+1];
        fclk_rise = slot_fclk[2*it];
        fclk_fall = slot_fclk[2*it+1];
      end else begin
        serial_rise = '0;
        serial_fall = '0;
        fclk_rise = 1'b0;
        fclk_fall = 1'b0;
      end
      @(negedge clk);
      it++;
    end
    pattern_mode = PATTERN_OFF;

    if (error_count !== 16'(t_expect[i])) begin
      $display("MISMATCH at %0t: error_count %0d expected %0d", $time, error_count,
               t_expect[i]);
      test_errors++;
    end
    if (pattern_ok !== exp_ok) begin
      $display("MISMATCH at %0t: pattern_ok %0b expected %0b", $time, pattern_ok, exp_ok);
      test_errors++;
    end

    if (test_errors == 0) begin
      passed++;
      $display("test %0s: ok", t_name[i]);
    end else begin
      failed++;
      errors += test_errors;
      $display("test %0s: failed with %0d errors", t_name[i], test_errors);
    end
  endtask

  // stops a run that never sees its words
  initial begin
    wait (tests_loaded);
    repeat (watchdog_cycles) @(posedge clk);
    $display("run hung: the expected sample_valid strobes never arrived");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    serial_rise = '0;
    serial_fall = '0;
    fclk_rise = 1'b0;
    fclk_fall = 1'b0;
    pattern_mode = PATTERN_OFF;
    error_clear = 1'b0;
    tests_loaded = 1'b0;
    num_tests = 0;
    total_words = 0;
    errors = 0;
    passed = 0;
    failed = 0;
    void'($urandom(32'ha533_db67));
    load_tests();
    watchdog_cycles = total_words * `ADC_WORD_CYCLES * 3 + 1000;
    tests_loaded = 1'b1;
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", num_tests, passed,
             failed, errors);
    if (failed == 0 && num_tests > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

endmodule

// File: logic/adc_link_top.sv
`timescale 1ns/1ps

`include "adc_defs.svh"

module adc_link_top import adc_frame_pkg::*, adc_pattern_pkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  // DDR samples per lane from the input flops
  input  logic [`ADC_LANES-1:0]             serial_rise,
  input  logic [`ADC_LANES-1:0]             serial_fall,
  // frame clock sampled the same way
  input  logic                              fclk_rise,
  input  logic                              fclk_fall,
  input  pattern_mode_t                     pattern_mode,
  input  logic                              error_clear,
  output logic [`ADC_LANES*`ADC_BITS-1:0]   samples,
  output logic                              sample_valid,
  output frame_state_t                      frame_state,
  output logic [15:0]                       error_count,
  output logic                              pattern_ok
);

  // frame alignment and word assembly
  adc_deserialise deserialise0 (
    .clk          (clk),
    .reset        (reset),
    .serial_rise  (serial_rise),
    .serial_fall  (serial_fall),
    .fclk_rise    (fclk_rise),
    .fclk_fall    (fclk_fall),
    .samples      (samples),
    .sample_valid (sample_valid),
    .frame_state  (frame_state)
  );

  // training pattern check on the same word stream
  adc_pattern_checker checker0 (
    .clk          (clk),
    .reset        (reset),
    .pattern_mode (pattern_mode),
    .error_clear  (error_clear),
    .samples      (samples),
    .sample_valid (sample_valid),
    .error_count  (error_count),
    .pattern_ok   (pattern_ok)
  );

endmodule

// File: logic/adc_pattern_checker.sv
`timescale 1ns/1ps

`include "adc_defs.svh"

module adc_pattern_checker import adc_pattern_pkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  input  pattern_mode_t                     pattern_mode,
  input  logic                              error_clear,
  input  logic [`ADC_LANES*`ADC_BITS-1:0]   samples,
  input  logic                              sample_valid,
  output logic [15:0]                       error_count,
  output logic                              pattern_ok
);

  // last word per lane, the ramp reference
  logic [`ADC_BITS-1:0] prev_word [`ADC_LANES];
  logic                 have_prev;
  pattern_mode_t        mode_q;

  logic        mode_changed;
  logic        ramp_ready;
  logic        check_word;
  logic [3:0]  wrong_lanes;
  logic [15:0] count_base;
  logic [16:0] count_sum;

  assign mode_changed = pattern_mode != mode_q;
  // a held word from before a mode change is no reference
  assign ramp_ready = have_prev && !mode_changed;

  // judge this word at all? ramp seeding words are not judged
  assign check_word = sample_valid &&
                      (pattern_mode == PATTERN_FIXED ||
                       (pattern_mode == PATTERN_RAMP && ramp_ready));

  // count lanes that miss the expected value
  always_comb begin
    logic [`ADC_BITS-1:0] lane_word;
    logic                 lane_bad;
    wrong_lanes = '0;
    for (int n = 0; n < `ADC_LANES; n++) begin
      lane_word = samples[n*`ADC_BITS +: `ADC_BITS];
      if (pattern_mode == PATTERN_FIXED) begin
        lane_bad = lane_word != `ADC_FIXED_PATTERN;
      end else begin
        // ramp wraps modulo 4096 through the 12 bit add
        lane_bad = lane_word != prev_word[n] + 12'd1;
      end
      wrong_lanes = wrong_lanes + 4'(lane_bad);
    end
  end

  // clear and a bad word in the same cycle keep the new errors
  assign count_base = error_clear ? 16'd0 : error_count;
  assign count_sum = {1'b0, count_base} + 17'(check_word ? wrong_lanes : 4'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      error_count <= '0;
      pattern_ok <= 1'b0;
      have_prev <= 1'b0;
      mode_q <= PATTERN_OFF;
    end else begin
      mode_q <= pattern_mode;

      // saturate at the top
      error_count <= count_sum[16] ? 16'hFFFF : count_sum[15:0];

      if (check_word) begin
        pattern_ok <= wrong_lanes == 4'd0;
      end

      if (sample_valid) begin
        have_prev <= 1'b1;
      end else if (mode_changed) begin
        have_prev <= 1'b0;
      end
    end
  end

  // reference words follow every valid word
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      for (int n = 0; n < `ADC_LANES; n++) begin
        prev_word[n] <= samples[n*`ADC_BITS +: `ADC_BITS];
      end
    end
  end

  // count only goes down through a clear or a reset
  count_monotonic: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) && !$past(error_clear) |-> error_count >= $past(error_count))
    else $error("error_count decreased without a clear");

endmodule

// File: logic/adc_deserialise.sv
`timescale 1ns/1ps

`include "adc_defs.svh"

module adc_deserialise import adc_frame_pkg::*; (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [`ADC_LANES-1:0]             serial_rise,
  input  logic [`ADC_LANES-1:0]             serial_fall,
  input  logic                              fclk_rise,
  input  logic                              fclk_fall,
  output logic [`ADC_LANES*`ADC_BITS-1:0]   samples,
  output logic                              sample_valid,
  output frame_state_t                      frame_state
);

  // previous cycle fall samples of the frame and the data
  logic                   fclk_fall_q;
  logic [`ADC_LANES-1:0]  serial_fall_q;

  // frame edge inside the rise half or the fall half of this cycle
  logic edge_rise;
  logic edge_fall;
  logic state_change;

  // bit pair counter within a word
  logic [2:0] index;
  // shift registers hold a whole word this cycle
  logic       word_end;
  // first word after a phase change is not trusted
  logic       drop;

  // steered DDR inputs as the even and odd bit of the pair
  logic                   steer_rise;
  logic [`ADC_LANES-1:0]  even_in;
  logic [`ADC_LANES-1:0]  odd_in;

  // entry 0 holds the oldest pair which is bits 1:0 of the word
  logic [`ADC_LANES-1:0]  even_sr [`ADC_WORD_CYCLES];
  logic [`ADC_LANES-1:0]  odd_sr  [`ADC_WORD_CYCLES];
  logic [`ADC_LANES*`ADC_BITS-1:0] word;

  // rising frame edge either between fall and rise of one cycle
  // or between last cycle's fall and this cycle's rise
  assign edge_fall = fclk_fall && !fclk_rise;
  assign edge_rise = fclk_rise && !fclk_fall_q;

  assign state_change = (edge_rise && frame_state != FRAME_RISE) ||
                        (edge_fall && frame_state != FRAME_FALL);

  // a rise edge steers its own cycle so the first pair lands right
  // even when the phase just moved
  assign steer_rise = edge_rise || frame_state != FRAME_FALL;

  // fall phase pairs span two cycles with last fall then this rise
  assign even_in = steer_rise ? serial_rise : serial_fall_q;
  assign odd_in  = steer_rise ? serial_fall : serial_rise;

  always_ff @(posedge clk) begin
    if (reset) begin
      // start high so a frame clock already high gives no false edge
      fclk_fall_q <= 1'b1;
      frame_state <= FRAME_HUNT;
      index <= '0;
      word_end <= 1'b0;
      drop <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      fclk_fall_q <= fclk_fall;

      // track the most recent edge
      if (edge_rise) begin
        frame_state <= FRAME_RISE;
      end else if (edge_fall) begin
        frame_state <= FRAME_FALL;
      end

      // rise edge already loads bits 1:0 this cycle while a fall edge loads them next
      if (edge_rise) begin
        index <= 3'd1;
      end else if (edge_fall) begin
        index <= 3'd0;
      end else if (index == 3'(`ADC_WORD_CYCLES - 1)) begin
        index <= 3'd0;
      end else begin
        index <= index + 3'd1;
      end

      word_end <= index == 3'(`ADC_WORD_CYCLES - 1);

      if (state_change) begin
        drop <= 1'b1;
      end else if (word_end) begin
        drop <= 1'b0;
      end

      sample_valid <= word_end && !drop && frame_state != FRAME_HUNT;
    end
  end

  // pair shift registers and the output word
  always_ff @(posedge clk) begin
    serial_fall_q <= serial_fall;
    even_sr[`ADC_WORD_CYCLES-1] <= even_in;
    odd_sr[`ADC_WORD_CYCLES-1] <= odd_in;
    for (int k = 0; k < `ADC_WORD_CYCLES - 1; k++) begin
      even_sr[k] <= even_sr[k+1];
      odd_sr[k] <= odd_sr[k+1];
    end
    if (word_end) begin
      samples <= word;
    end
  end

  // interleave pairs back into LSB first words with lane n at bits 12n+11:12n
  always_comb begin
    for (int n = 0; n < `ADC_LANES; n++) begin
      for (int k = 0; k < `ADC_WORD_CYCLES; k++) begin
        word[n*`ADC_BITS + 2*k] = even_sr[k][n];
        word[n*`ADC_BITS + 2*k + 1] = odd_sr[k][n];
      end
    end
  end

  // counter must stay inside one word
  index_in_range: assert property (@(posedge clk) disable iff (reset)
    index <= 3'(`ADC_WORD_CYCLES - 1))
    else $error("word index out of range");

  // one strobe per word and never back to back
  valid_single_pulse: assert property (@(posedge clk) disable iff (reset)
    sample_valid |=> !sample_valid)
    else $error("sample_valid high on consecutive cycles");

endmodule

// File: logic/adc_pattern_pkg.sv
// link training pattern types for the checker

package adc_pattern_pkg;

  // test pattern that the ADC is programmed to send
  // encoding matches the mode numbers used by the test records
  typedef enum logic [1:0] {
    // normal conversion data, nothing to check
    PATTERN_OFF = 2'd0,
    // every word is the fixed pattern
    PATTERN_FIXED = 2'd1,
    // each lane counts up by one per word and wraps at 4095
    PATTERN_RAMP = 2'd2
  } pattern_mode_t;

endpackage

// File: logic/adc_frame_pkg.sv
// frame alignment types for the deserialiser

package adc_frame_pkg;

  // where the rising frame clock edge falls within a clk cycle
  // HUNT until the first edge after reset
  typedef enum logic [1:0] {
    // no frame edge seen yet
    FRAME_HUNT = 2'd0,
    // edge in the rise sample, bit 0 is the rise bit of the edge cycle
    FRAME_RISE = 2'd1,
    // edge in the fall sample, bit 0 is the fall bit of the edge cycle
    FRAME_FALL = 2'd2
  } frame_state_t;

endpackage

// File: logic/adc_defs.svh
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// serial data lanes on the link, one ADC channel each
`define ADC_LANES 8

// bits per sample word
`define ADC_BITS 12

// clk cycles per word, two DDR bits per cycle
`define ADC_WORD_CYCLES 6

// word the ADC repeats in fixed test pattern mode
`define ADC_FIXED_PATTERN 12'hA5C

`endif
